//--- Makefile
# Verilator flow for the tcdm interconnect

VERILATOR ?= verilator
TOP       ?= tb_tcdm_interconnect
FILELIST  ?= tcdm_ic.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= All tests passed!

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(BUILD_DIR)/V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- bench/tb_tcdm_interconnect.sv
// tcdm interconnect testbench
// emulates the banks, drives random, permutation, walk and
// hot-spot patterns on the ports and checks responses with assertions

`timescale 1ns/1ps

module tb_tcdm_interconnect;

  localparam int ClkPeriod = 8;
  // stimulus modes
  localparam int ModeIdle  = 0;
  localparam int ModeRand  = 1;
  localparam int ModePerm  = 2;
  localparam int ModeWalk  = 3;
  localparam int ModeConst = 4;
  // phase lengths in cycles
  localparam int RandCyc   = 300;
  localparam int PatCyc    = 200;
  localparam int TotalCyc  = 5 + 2 + 3 * RandCyc + 3 * PatCyc + 40;

  logic clk_i = 1'b0;
  logic rst_ni;
  logic [tcdm_pkg::NumMaster-1:0]                  req_i;
  tcdm_pkg::master_req_t [tcdm_pkg::NumMaster-1:0] preq_i;
  logic [tcdm_pkg::NumMaster-1:0]                  gnt_o;
  logic [tcdm_pkg::NumMaster-1:0]                  vld_o;
  tcdm_pkg::data_t [tcdm_pkg::NumMaster-1:0]       rdata_o;
  logic [tcdm_pkg::NumBanks-1:0]                   cs_o;
  tcdm_pkg::bank_req_t [tcdm_pkg::NumBanks-1:0]    breq_o;
  tcdm_pkg::data_t [tcdm_pkg::NumBanks-1:0]        rdata_i;

  // bank arrays and the expected-value copy
  tcdm_pkg::data_t mem    [tcdm_pkg::NumBanks][2**tcdm_pkg::MemAddrBits];
  tcdm_pkg::data_t shadow [tcdm_pkg::NumBanks][2**tcdm_pkg::MemAddrBits];

  logic [31:0] lfsr_q;
  int          mode;
  int          prob_sel;
  int unsigned walk_cnt;
  int          post_cnt;
  int          const_cnt;
  int          mismatch_cnt;
  int          fail_cnt;
  logic [tcdm_pkg::NumMaster-1:0] gnt_seen;
  logic [tcdm_pkg::NumMaster-1:0] exp_vld;
  logic [tcdm_pkg::NumMaster-1:0] exp_rd;
  tcdm_pkg::data_t                exp_data [tcdm_pkg::NumMaster];
  int                             wait_cnt [tcdm_pkg::NumMaster];
  logic [tcdm_pkg::NumMaster-1:0] gnt_hist [tcdm_pkg::NumMaster];

  tcdm_interconnect i_dut (
    .clk_i   ( clk_i   ),
    .rst_ni  ( rst_ni  ),
    .req_i   ( req_i   ),
    .preq_i  ( preq_i  ),
    .gnt_o   ( gnt_o   ),
    .vld_o   ( vld_o   ),
    .rdata_o ( rdata_o ),
    .cs_o    ( cs_o    ),
    .breq_o  ( breq_o  ),
    .rdata_i ( rdata_i )
  );

  always #(ClkPeriod / 2) clk_i = ~clk_i;

  ////////////////////////////////////////////////////////////////////////////
  // random source
  ////////////////////////////////////////////////////////////////////////////

  // galois lfsr, right shifting
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'hA300_0000;
    end
    return s >> 1;
  endfunction

  // one lfsr step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v      = {v[30:0], lfsr_q[0]};
      lfsr_q = lfsr_next(lfsr_q);
    end
    return v;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // bank emulation
  ////////////////////////////////////////////////////////////////////////////

  // access at the cs edge, read data during the next cycle
  always @(posedge clk_i) begin : p_banks
    for (int b = 0; b < tcdm_pkg::NumBanks; b++) begin
      if (cs_o[b]) begin
        if (breq_o[b].wen) begin
          for (int k = 0; k < tcdm_pkg::StrbWidth; k++) begin
            if (breq_o[b].be[k]) mem[b][breq_o[b].row][8*k +: 8] = breq_o[b].wdata[8*k +: 8];
          end
        end else begin
          rdata_i[b] <= mem[b][breq_o[b].row];
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////////////////////

  // new request only when idle or just granted
  always @(posedge clk_i) begin : p_stim
    logic [2:0]            perm [tcdm_pkg::NumBanks];
    logic [2:0]            tmp;
    int                    j;
    logic                  go;
    tcdm_pkg::row_t        rw;
    tcdm_pkg::bank_idx_t   bk;
    tcdm_pkg::master_req_t nreq;
    for (int b = 0; b < tcdm_pkg::NumBanks; b++) begin
      perm[b] = 3'(b);
    end
    // shuffle, first ports take distinct banks
    for (int b = tcdm_pkg::NumBanks - 1; b > 0; b--) begin
      j       = int'(rand_bits(3)) % (b + 1);
      tmp     = perm[b];
      perm[b] = perm[j];
      perm[j] = tmp;
    end
    for (int m = 0; m < tcdm_pkg::NumMaster; m++) begin
      if (!req_i[m] || gnt_seen[m]) begin
        case (prob_sel)
          0:       go = (rand_bits(2) == 32'd0);
          1:       go = (rand_bits(1) != 32'd0);
          default: go = 1'b1;
        endcase
        if (mode == ModeIdle) go = 1'b0;
        nreq.wen   = (rand_bits(1) != 32'd0);
        nreq.wdata = rand_bits(32);
        nreq.be    = tcdm_pkg::strb_t'(rand_bits(4));
        // few rows so that reads hit earlier writes
        rw = tcdm_pkg::row_t'(rand_bits(3));
        bk = tcdm_pkg::bank_idx_t'(rand_bits(3));
        case (mode)
          ModePerm:  nreq.addr = {21'b0, rw, perm[m], 2'b00};
          ModeWalk:  nreq.addr = tcdm_pkg::addr_t'(((walk_cnt * 4 + m) * 4) & 32'h7FF);
          ModeConst: nreq.addr = 32'h0000_0094;
          default:   nreq.addr = {21'b0, rw, bk, 2'b00};
        endcase
        req_i[m]    <= go;
        preq_i[m]   <= nreq;
      end
    end
    if (mode == ModeWalk) walk_cnt <= walk_cnt + 1;
  end

  ////////////////////////////////////////////////////////////////////////////
  // checks, sampled mid-cycle
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge clk_i) begin : p_check
    int                            bank_hits [tcdm_pkg::NumBanks];
    logic                          all_perm;
    logic                          const_chk;
    logic [tcdm_pkg::NumBanks-1:0] bank_used;
    tcdm_pkg::bank_idx_t           bk;
    tcdm_pkg::row_t                rw;
    // responses to the grants of the last cycle
    for (int m = 0; m < tcdm_pkg::NumMaster; m++) begin
      assert (vld_o[m] == exp_vld[m]) else begin
        $display("MISMATCH at %0t: port %0d vld %b, expected %b", $time, m, vld_o[m], exp_vld[m]);
        mismatch_cnt++;
      end
      if (exp_vld[m] && exp_rd[m]) begin
        assert (rdata_o[m] == exp_data[m]) else begin
          $display("MISMATCH at %0t: port %0d rdata %h, expected %h",
                   $time, m, rdata_o[m], exp_data[m]);
          mismatch_cnt++;
        end
      end
    end
    // quiet outputs around reset
    if (!rst_ni || post_cnt < 2) begin
      assert (cs_o == '0 && gnt_o == '0 && vld_o == '0) else begin
        $display("at %0t: outputs active around reset", $time);
        fail_cnt++;
      end
    end
    if (rst_ni) post_cnt++;
    const_cnt = (mode == ModeConst) ? const_cnt + 1 : 0;
    const_chk = (const_cnt >= 2 * tcdm_pkg::NumMaster);
    // requesting ports all on different banks
    all_perm  = 1'b1;
    bank_used = '0;
    for (int m = 0; m < tcdm_pkg::NumMaster; m++) begin
      bk = preq_i[m].addr[tcdm_pkg::AddrWordOff +: tcdm_pkg::BankBits];
      if (req_i[m]) begin
        if (bank_used[bk]) all_perm = 1'b0;
        bank_used[bk] = 1'b1;
      end
    end
    for (int b = 0; b < tcdm_pkg::NumBanks; b++) begin
      bank_hits[b] = 0;
    end
    for (int m = 0; m < tcdm_pkg::NumMaster; m++) begin
      exp_vld[m] = gnt_o[m];
      exp_rd[m]  = 1'b0;
      bk = preq_i[m].addr[tcdm_pkg::AddrWordOff +: tcdm_pkg::BankBits];
      rw = preq_i[m].addr[tcdm_pkg::AddrWordOff + tcdm_pkg::BankBits +: tcdm_pkg::MemAddrBits];
      if (gnt_o[m]) begin
        assert (req_i[m]) else begin
          $display("at %0t: port %0d granted without a request", $time, m);
          fail_cnt++;
        end
        bank_hits[bk]++;
        assert (cs_o[bk] && breq_o[bk].row == rw && breq_o[bk].wen == preq_i[m].wen) else begin
          $display("MISMATCH at %0t: port %0d bank %0d access does not match request",
                   $time, m, bk);
          mismatch_cnt++;
        end
        exp_rd[m]   = !preq_i[m].wen;
        exp_data[m] = shadow[bk][rw];
        if (preq_i[m].wen) begin
          for (int k = 0; k < tcdm_pkg::StrbWidth; k++) begin
            if (preq_i[m].be[k]) shadow[bk][rw][8*k +: 8] = preq_i[m].wdata[8*k +: 8];
          end
        end
      end
      // distinct banks leave nobody waiting
      if (mode == ModePerm && all_perm && req_i[m]) begin
        assert (gnt_o[m]) else begin
          $display("at %0t: port %0d not granted on a conflict-free cycle", $time, m);
          fail_cnt++;
        end
      end
      wait_cnt[m] = (req_i[m] && !gnt_o[m]) ? wait_cnt[m] + 1 : 0;
      gnt_hist[m] = {gnt_hist[m][tcdm_pkg::NumMaster-2:0], gnt_o[m]};
      if (const_chk) begin
        assert (wait_cnt[m] <= tcdm_pkg::NumMaster - 1 && $countones(gnt_hist[m]) == 1)
          else begin
          $display("at %0t: port %0d starved on the shared bank", $time, m);
          fail_cnt++;
        end
      end
    end
    for (int b = 0; b < tcdm_pkg::NumBanks; b++) begin
      assert (bank_hits[b] <= 1 && cs_o[b] == (bank_hits[b] == 1)) else begin
        $display("at %0t: bank %0d select does not match the grants", $time, b);
        fail_cnt++;
      end
    end
    gnt_seen = gnt_o;
  end

  ////////////////////////////////////////////////////////////////////////////
  // sequence and watchdog
  ////////////////////////////////////////////////////////////////////////////

  task automatic run_phase(input int new_mode, input int new_prob, input int cycles);
    mode     <= new_mode;
    prob_sel <= new_prob;
    repeat (cycles) @(posedge clk_i);
  endtask

  initial begin : p_main
    lfsr_q       = 32'ha23233f7;
    mode         = ModeIdle;
    prob_sel     = 2;
    walk_cnt     = 0;
    post_cnt     = 0;
    const_cnt    = 0;
    mismatch_cnt = 0;
    fail_cnt     = 0;
    gnt_seen     = '0;
    exp_vld      = '0;
    exp_rd       = '0;
    rst_ni       = 1'b0;
    req_i        = '0;
    preq_i       = '0;
    rdata_i      = '0;
    for (int m = 0; m < tcdm_pkg::NumMaster; m++) begin
      wait_cnt[m] = 0;
      gnt_hist[m] = '0;
    end
    // bank contents from the lfsr
    for (int b = 0; b < tcdm_pkg::NumBanks; b++) begin
      for (int r = 0; r < 2**tcdm_pkg::MemAddrBits; r++) begin
        mem[b][r]    = rand_bits(32);
        shadow[b][r] = mem[b][r];
      end
    end
    repeat (5) @(posedge clk_i);
    rst_ni <= 1'b1;
    repeat (2) @(posedge clk_i);
    run_phase(ModeRand, 0, RandCyc);
    run_phase(ModeRand, 1, RandCyc);
    run_phase(ModeRand, 2, RandCyc);
    run_phase(ModePerm, 2, PatCyc);
    run_phase(ModeWalk, 2, PatCyc);
    run_phase(ModeConst, 2, PatCyc);
    // drain held requests and last responses
    mode <= ModeIdle;
    @(posedge clk_i);
    while (req_i != '0) @(posedge clk_i);
    repeat (3) @(posedge clk_i);
    $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
    if (mismatch_cnt == 0 && fail_cnt == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  initial begin : p_watchdog
    #((TotalCyc + 200) * ClkPeriod);
    $display("watchdog expired: run did not complete in time");
    $display("Test failures found");
    $finish;
  end

endmodule

//--- hdl/tcdm_addr_decode.sv
// tcdm address decode
// splits each port byte address into bank index and row
// (word interleaved) and builds the port-to-bank request matrix

`timescale 1ns/1ps

module tcdm_addr_decode (
  // port side
  input  logic [tcdm_pkg::NumMaster-1:0]                          req_i,
  input  tcdm_pkg::master_req_t [tcdm_pkg::NumMaster-1:0]         preq_i,
  // decoded requests
  output tcdm_pkg::dec_req_t [tcdm_pkg::NumMaster-1:0]            dreq_o,
  output logic [tcdm_pkg::NumMaster-1:0][tcdm_pkg::NumBanks-1:0]  bank_req_o
);

  ////////////////////////////////////////////////////////////////////////////
  // address split
  ////////////////////////////////////////////////////////////////////////////

  // addr layout, lsb first:
  //   byte offset | bank | row | unused
  // consecutive words land in consecutive banks

  always_comb begin : p_decode
    for (int m = 0; m < tcdm_pkg::NumMaster; m++) begin
      // bank field just above byte offset
      dreq_o[m].bank  = preq_i[m].addr[tcdm_pkg::AddrWordOff +: tcdm_pkg::BankBits];
      // row field above bank
      dreq_o[m].row   = preq_i[m].addr[tcdm_pkg::RowOff +: tcdm_pkg::MemAddrBits];
      // payload passes unchanged
      dreq_o[m].wen   = preq_i[m].wen;
      dreq_o[m].wdata = preq_i[m].wdata;
      dreq_o[m].be    = preq_i[m].be;

      // one bank bit per requesting port
      bank_req_o[m] = '0;
      if (req_i[m]) begin
        bank_req_o[m][dreq_o[m].bank] = 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////////////////////

  // row of the matrix must be one-hot for a request, zero otherwise
  for (genvar m = 0; m < tcdm_pkg::NumMaster; m++) begin : g_chk
    always_comb begin : p_onehot
      assert final ($onehot0(bank_req_o[m]) && ((|bank_req_o[m]) == req_i[m]))
        else $error("port %0d: bank request not one-hot (%b)", m, bank_req_o[m]);
    end
  end

endmodule

//--- hdl/tcdm_bank_arbiter.sv
// tcdm bank arbiter
// one round-robin arbiter per bank; picks a winner among
// the ports targeting the bank, drives the bank request and
// returns the combinational port grants plus winner index

`timescale 1ns/1ps

module tcdm_bank_arbiter (
  input  logic                                                    clk_i,
  input  logic                                                    rst_ni,
  // decoded port requests
  input  tcdm_pkg::dec_req_t [tcdm_pkg::NumMaster-1:0]            dreq_i,
  input  logic [tcdm_pkg::NumMaster-1:0][tcdm_pkg::NumBanks-1:0]  bank_req_i,
  // bank side
  output logic [tcdm_pkg::NumBanks-1:0]                           cs_o,
  output tcdm_pkg::bank_req_t [tcdm_pkg::NumBanks-1:0]            breq_o,
  // port grants
  output logic [tcdm_pkg::NumMaster-1:0]                          gnt_o,
  // winner per bank, to the response stage
  output tcdm_pkg::master_idx_t [tcdm_pkg::NumBanks-1:0]          win_idx_o
);

  // round-robin pointer per bank, highest priority port
  tcdm_pkg::master_idx_t [tcdm_pkg::NumBanks-1:0] rr_ptr_q;
  // grant matrix, bank x port
  logic [tcdm_pkg::NumBanks-1:0][tcdm_pkg::NumMaster-1:0] gnt_mat;

  ////////////////////////////////////////////////////////////////////////////
  // arbitration
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin : p_arb
    tcdm_pkg::master_idx_t cand;
    cand = '0;
    for (int b = 0; b < tcdm_pkg::NumBanks; b++) begin
      cs_o[b]      = 1'b0;
      win_idx_o[b] = rr_ptr_q[b];
      gnt_mat[b]   = '0;
      // scan upward from pointer, wraps via index width
      for (int k = 0; k < tcdm_pkg::NumMaster; k++) begin
        cand = rr_ptr_q[b] + tcdm_pkg::master_idx_t'(k);
        if (!cs_o[b] && bank_req_i[cand][b]) begin
          cs_o[b]      = 1'b1;
          win_idx_o[b] = cand;
        end
      end
      if (cs_o[b]) begin
        gnt_mat[b][win_idx_o[b]] = 1'b1;
      end
      // forward winner payload; don't care while cs is low
      breq_o[b].row   = dreq_i[win_idx_o[b]].row;
      breq_o[b].wen   = dreq_i[win_idx_o[b]].wen;
      breq_o[b].wdata = dreq_i[win_idx_o[b]].wdata;
      breq_o[b].be    = dreq_i[win_idx_o[b]].be;
    end
  end

  // port granted if any bank chose it
  always_comb begin : p_gnt
    for (int m = 0; m < tcdm_pkg::NumMaster; m++) begin
      gnt_o[m] = 1'b0;
      for (int b = 0; b < tcdm_pkg::NumBanks; b++) begin
        gnt_o[m] = gnt_o[m] | gnt_mat[b][m];
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // pointer update
  ////////////////////////////////////////////////////////////////////////////

  // after a grant the port next to the winner gets priority
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_ptr
    if (!rst_ni) begin
      rr_ptr_q <= '0;
    end else begin
      for (int b = 0; b < tcdm_pkg::NumBanks; b++) begin
        if (cs_o[b]) begin
          rr_ptr_q[b] <= tcdm_pkg::master_idx_t'(win_idx_o[b] + 1'b1);
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////////////////////

  for (genvar m = 0; m < tcdm_pkg::NumMaster; m++) begin : g_chk
    logic [tcdm_pkg::NumBanks-1:0] gnt_col;

    for (genvar b = 0; b < tcdm_pkg::NumBanks; b++) begin : g_col
      assign gnt_col[b] = gnt_mat[b][m];
    end

    // grant only for the bank the decoder selected
    gnt_has_req : assert property (
      @(posedge clk_i) disable iff (!rst_ni)
      gnt_o[m] |-> bank_req_i[m][dreq_i[m].bank])
      else $error("port %0d granted without matching request", m);

    // a port is never served by two banks at once
    gnt_one_bank : assert property (
      @(posedge clk_i) disable iff (!rst_ni)
      $onehot0(gnt_col))
      else $error("port %0d granted by several banks (%b)", m, gnt_col);
  end

endmodule

//--- hdl/tcdm_interconnect.sv
// tcdm interconnect top
// connects the core ports to word-interleaved single-cycle banks:
// address decode, per-bank round-robin arbitration with same-cycle
// grant, and response routing with read data one cycle later

`timescale 1ns/1ps

module tcdm_interconnect (
  input  logic                                            clk_i,
  input  logic                                            rst_ni,

  ////////////////////////////////////////////////////////////////////////////
  // port side
  ////////////////////////////////////////////////////////////////////////////

  // request strobe, held until gnt_o
  input  logic [tcdm_pkg::NumMaster-1:0]                  req_i,
  input  tcdm_pkg::master_req_t [tcdm_pkg::NumMaster-1:0] preq_i,
  // same-cycle grant
  output logic [tcdm_pkg::NumMaster-1:0]                  gnt_o,
  // response one cycle after grant, reads and writes
  output logic [tcdm_pkg::NumMaster-1:0]                  vld_o,
  output tcdm_pkg::data_t [tcdm_pkg::NumMaster-1:0]       rdata_o,

  ////////////////////////////////////////////////////////////////////////////
  // bank side
  ////////////////////////////////////////////////////////////////////////////

  // banks always accept, no bank grant
  output logic [tcdm_pkg::NumBanks-1:0]                   cs_o,
  output tcdm_pkg::bank_req_t [tcdm_pkg::NumBanks-1:0]    breq_o,
  input  tcdm_pkg::data_t [tcdm_pkg::NumBanks-1:0]        rdata_i
);

  // decoded requests
  tcdm_pkg::dec_req_t [tcdm_pkg::NumMaster-1:0]           dreq;
  // port-to-bank request matrix
  logic [tcdm_pkg::NumMaster-1:0][tcdm_pkg::NumBanks-1:0] bank_req;
  // winning port per bank
  tcdm_pkg::master_idx_t [tcdm_pkg::NumBanks-1:0]         win_idx;

  // bank and row split
  tcdm_addr_decode i_decode (
    .req_i      ( req_i    ),
    .preq_i     ( preq_i   ),
    .dreq_o     ( dreq     ),
    .bank_req_o ( bank_req )
  );

  // per-bank round robin, combinational grant
  tcdm_bank_arbiter i_arbiter (
    .clk_i      ( clk_i    ),
    .rst_ni     ( rst_ni   ),
    .dreq_i     ( dreq     ),
    .bank_req_i ( bank_req ),
    .cs_o       ( cs_o     ),
    .breq_o     ( breq_o   ),
    .gnt_o      ( gnt_o    ),
    .win_idx_o  ( win_idx  )
  );

  // one cycle later, data back to the winner
  tcdm_resp_route i_resp (
    .clk_i      ( clk_i    ),
    .rst_ni     ( rst_ni   ),
    .cs_i       ( cs_o     ),
    .win_idx_i  ( win_idx  ),
    .rdata_i    ( rdata_i  ),
    .vld_o      ( vld_o    ),
    .rdata_o    ( rdata_o  )
  );

endmodule

//--- hdl/tcdm_pkg.sv
// tcdm interconnect shared definitions
// sizes, word/address types and request structs used by
// the decode, arbitration and response stages

package tcdm_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // sizes
  ////////////////////////////////////////////////////////////////////////////

  localparam int unsigned NumMaster   = 4;
  localparam int unsigned NumBanks    = 8;
  localparam int unsigned DataWidth   = 32;
  localparam int unsigned MemAddrBits = 6;
  // byte offset inside a word
  localparam int unsigned AddrWordOff = 2;

  // derived widths
  localparam int unsigned AddrWidth  = 32;
  localparam int unsigned StrbWidth  = DataWidth / 8;
  localparam int unsigned BankBits   = $clog2(NumBanks);
  localparam int unsigned MasterBits = $clog2(NumMaster);
  // row field sits right above the bank field
  localparam int unsigned RowOff     = AddrWordOff + BankBits;

  ////////////////////////////////////////////////////////////////////////////
  // vector types
  ////////////////////////////////////////////////////////////////////////////

  typedef logic [AddrWidth-1:0]   addr_t;
  typedef logic [DataWidth-1:0]   data_t;
  typedef logic [StrbWidth-1:0]   strb_t;
  typedef logic [BankBits-1:0]    bank_idx_t;
  typedef logic [MemAddrBits-1:0] row_t;
  typedef logic [MasterBits-1:0]  master_idx_t;

  // request as presented by a core port
  typedef struct packed {
    addr_t addr;
    logic  wen;
    data_t wdata;
    strb_t be;
  } master_req_t;

  // request as seen by one bank
  typedef struct packed {
    row_t  row;
    logic  wen;
    data_t wdata;
    strb_t be;
  } bank_req_t;

  // port request after address split
  typedef struct packed {
    bank_idx_t bank;
    row_t      row;
    logic      wen;
    data_t     wdata;
    strb_t     be;
  } dec_req_t;

endpackage

//--- hdl/tcdm_resp_route.sv
// tcdm response routing
// registers per bank whether it was accessed and by which port,
// then raises the port valid and steers the bank read data back
// one cycle after the grant

`timescale 1ns/1ps

module tcdm_resp_route (
  input  logic                                            clk_i,
  input  logic                                            rst_ni,
  // from arbiter
  input  logic [tcdm_pkg::NumBanks-1:0]                   cs_i,
  input  tcdm_pkg::master_idx_t [tcdm_pkg::NumBanks-1:0]  win_idx_i,
  // bank read data, valid the cycle after cs
  input  tcdm_pkg::data_t [tcdm_pkg::NumBanks-1:0]        rdata_i,
  // port responses
  output logic [tcdm_pkg::NumMaster-1:0]                  vld_o,
  output tcdm_pkg::data_t [tcdm_pkg::NumMaster-1:0]       rdata_o
);

  logic [tcdm_pkg::NumBanks-1:0]                          cs_q;
  tcdm_pkg::master_idx_t [tcdm_pkg::NumBanks-1:0]         win_q;
  // port x bank, which bank answers which port
  logic [tcdm_pkg::NumMaster-1:0][tcdm_pkg::NumBanks-1:0] hit;

  ////////////////////////////////////////////////////////////////////////////
  // access record
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_cs
    if (!rst_ni) begin
      cs_q <= '0;
    end else begin
      cs_q <= cs_i;
    end
  end

  // winner index only matters when cs_q is set
  always_ff @(posedge clk_i) begin : p_win
    win_q <= win_idx_i;
  end

  ////////////////////////////////////////////////////////////////////////////
  // steering
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin : p_route
    for (int m = 0; m < tcdm_pkg::NumMaster; m++) begin
      vld_o[m]   = 1'b0;
      rdata_o[m] = '0;
      for (int b = 0; b < tcdm_pkg::NumBanks; b++) begin
        hit[m][b] = cs_q[b] && (win_q[b] == tcdm_pkg::master_idx_t'(m));
        if (hit[m][b]) begin
          vld_o[m]   = 1'b1;
          rdata_o[m] = rdata_i[b];
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////////////////////

  // at most one bank answers a port per cycle
  for (genvar m = 0; m < tcdm_pkg::NumMaster; m++) begin : g_chk
    resp_unique : assert property (
      @(posedge clk_i) disable iff (!rst_ni)
      $onehot0(hit[m]))
      else $error("port %0d: responses from several banks (%b)", m, hit[m]);
  end

endmodule

//--- tcdm_ic.f
hdl/tcdm_pkg.sv
hdl/tcdm_addr_decode.sv
hdl/tcdm_bank_arbiter.sv
hdl/tcdm_resp_route.sv
hdl/tcdm_interconnect.sv
bench/tb_tcdm_interconnect.sv
